// File: design/lc3b_types_pkg.sv
package lc3b_types_pkg;

    typedef logic [15:0] lc3b_word;

    typedef enum logic [3:0] {
        op_br   = 4'b0000,
        op_add  = 4'b0001,
        op_ldb  = 4'b0010,
        op_stb  = 4'b0011,
        op_jsr  = 4'b0100,
        op_and  = 4'b0101,
        op_ldr  = 4'b0110,
        op_str  = 4'b0111,
        op_rti  = 4'b1000,
        op_not  = 4'b1001,
        op_ldi  = 4'b1010,
        op_sti  = 4'b1011,
        op_jmp  = 4'b1100,
        op_shf  = 4'b1101,
        op_lea  = 4'b1110,
        op_trap = 4'b1111
    } lc3b_opcode;

    typedef enum logic [2:0] {
        pc_plus2           = 3'd0,
        alu                = 3'd1,
        pcn                = 3'd2,
        mdr                = 3'd3,
        branch_address     = 3'd4,
        mispredict_address = 3'd5
    } lc3b_pc_mux_sel;

    // barrier control bits, 11 in all.
    typedef struct packed {
        lc3b_pc_mux_sel pc_mux_sel;
        logic           load_regfile;
        logic           load_cc;
        logic           mem_read;
        logic           mem_write;
        logic           mem_byte;
        logic [2:0]     alu_op;
    } lc3b_control_word;

    typedef struct packed {
        lc3b_opcode opcode;
        logic       n;
        logic       z;
        logic       p;
        logic [8:0] offset9;
    } lc3b_br_format;

    typedef struct packed {
        lc3b_opcode opcode;
        logic [2:0] dr;
        logic [2:0] sr1;
        logic [5:0] operand; // imm5, sr2 or offset6.
    } lc3b_gen_format;

    typedef union packed {
        lc3b_br_format  br;
        lc3b_gen_format gen;
    } lc3b_instr;

    typedef struct packed {
        logic active;
        logic exclusive;
        logic barrier_IF_ID_reset;
        logic barrier_ID_EX_reset;
        logic barrier_EX_MEM_reset;
        logic barrier_MEM_WB_reset;
        logic barrier_IF_ID_stall;
        logic barrier_ID_EX_stall;
        logic barrier_EX_MEM_stall;
        logic barrier_MEM_WB_stall;
        logic barrier_ID_EX_force_sr1_load;
        logic barrier_ID_EX_force_sr2_load;
        logic stage_IF_stall;
        logic stage_ID_stall;
        logic stage_EX_stall;
        logic stage_MEM_stall;
        logic stage_WB_stall;
    } lc3b_pipeline_control_word;

    localparam int PRED_INDEX_BITS = 4;
    localparam int QUEUE_DEPTH     = 4; // at least barriers from IF to EX/MEM plus one.

endpackage

// File: design/branch_predictor.sv
`timescale 1ns/100ps

module branch_predictor #(
    parameter int PRED_INDEX_BITS = lc3b_types_pkg::PRED_INDEX_BITS,
    parameter int QUEUE_DEPTH     = lc3b_types_pkg::QUEUE_DEPTH
) (
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     stall,
    input  logic                     flush,
    input  logic                     load,
    input  lc3b_types_pkg::lc3b_word pc,
    input  logic                     update,
    input  logic                     update_value,
    output logic                     prediction
);

    localparam int TABLE_SIZE = 2 ** PRED_INDEX_BITS;
    localparam int PTR_BITS   = $clog2(QUEUE_DEPTH);

    logic [1:0]                 counters [TABLE_SIZE];
    logic [PRED_INDEX_BITS-1:0] index_mem [QUEUE_DEPTH];
    logic [PTR_BITS-1:0]        rd_ptr;
    logic [PTR_BITS-1:0]        wr_ptr;
    logic [PRED_INDEX_BITS-1:0] fetch_index;
    logic [PRED_INDEX_BITS-1:0] train_index;

    function automatic logic [PTR_BITS-1:0] next_ptr(input logic [PTR_BITS-1:0] ptr);
        return (ptr == PTR_BITS'(QUEUE_DEPTH - 1)) ? '0 : ptr + 1'b1;
    endfunction

    assign fetch_index = pc[PRED_INDEX_BITS:1];
    assign train_index = index_mem[rd_ptr]; // index of the resolving branch.
    assign prediction  = counters[fetch_index][1];

    // 2-bit saturating counters that reset weakly not-taken.
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < TABLE_SIZE; i++) begin
                counters[i] <= 2'b01;
            end
        end else if (!stall && update) begin
            if (update_value && counters[train_index] != 2'b11) begin
                counters[train_index] <= counters[train_index] + 2'b01;
            end else if (!update_value && counters[train_index] != 2'b00) begin
                counters[train_index] <= counters[train_index] - 2'b01;
            end
        end
    end

    // index fifo tracks the prediction queue entry for entry.
    always_ff @(posedge clk) begin
        if (reset) begin
            rd_ptr <= '0;
            wr_ptr <= '0;
        end else if (!stall) begin
            if (flush) begin
                rd_ptr <= '0;
                wr_ptr <= '0;
            end else begin
                if (update) rd_ptr <= next_ptr(rd_ptr);
                if (load) wr_ptr <= next_ptr(wr_ptr);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!stall && load && !flush) begin
            index_mem[wr_ptr] <= fetch_index;
        end
    end

endmodule

// File: design/branch_waterfall_queue.sv
`timescale 1ns/100ps

module branch_waterfall_queue #(
    parameter int QUEUE_DEPTH = lc3b_types_pkg::QUEUE_DEPTH
) (
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     stall,
    input  logic                     flush,
    input  logic                     load,
    input  lc3b_types_pkg::lc3b_word mispredict_address_in,
    input  logic                     prediction_in,
    input  logic                     update,
    input  logic                     correct,
    output lc3b_types_pkg::lc3b_word mispredict_address,
    output logic                     prediction
);

    import lc3b_types_pkg::*;

    localparam int PTR_BITS = $clog2(QUEUE_DEPTH);
    localparam int CNT_BITS = $clog2(QUEUE_DEPTH + 1);

    typedef struct packed {
        lc3b_word address; // path not taken at fetch.
        logic     taken;
    } queue_entry;

    queue_entry          entries [QUEUE_DEPTH];
    logic [PTR_BITS-1:0] rd_ptr;
    logic [PTR_BITS-1:0] wr_ptr;
    logic [CNT_BITS-1:0] count;
    logic [15:0]         hit_count;

    function automatic logic [PTR_BITS-1:0] next_ptr(input logic [PTR_BITS-1:0] ptr);
        return (ptr == PTR_BITS'(QUEUE_DEPTH - 1)) ? '0 : ptr + 1'b1;
    endfunction

    assign mispredict_address = entries[rd_ptr].address;
    assign prediction         = entries[rd_ptr].taken;

    // pop before push. a flush empties the queue after the pop.
    always_ff @(posedge clk) begin
        if (reset) begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            count  <= '0;
        end else if (!stall) begin
            if (flush) begin
                rd_ptr <= '0;
                wr_ptr <= '0;
                count  <= '0;
            end else begin
                if (update) rd_ptr <= next_ptr(rd_ptr);
                if (load) wr_ptr <= next_ptr(wr_ptr);
                count <= count + CNT_BITS'(load) - CNT_BITS'(update);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!stall && load && !flush) begin
            entries[wr_ptr] <= '{address: mispredict_address_in, taken: prediction_in};
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            hit_count <= '0;
        end else if (!stall && update && correct) begin
            hit_count <= hit_count + 16'd1; // statistics only.
        end
    end

endmodule

// File: design/branch_controller.sv
`timescale 1ns/100ps

module branch_controller #(
    parameter int PRED_INDEX_BITS = lc3b_types_pkg::PRED_INDEX_BITS,
    parameter int QUEUE_DEPTH     = lc3b_types_pkg::QUEUE_DEPTH
) (
    input  logic                                      clk,
    input  logic                                      reset,
    input  logic                                      stall,
    input  lc3b_types_pkg::lc3b_instr                 if_ir,
    input  lc3b_types_pkg::lc3b_word                  if_pc,
    input  logic                                      if_valid,
    input  lc3b_types_pkg::lc3b_opcode                if_id_opcode,
    input  logic                                      if_id_valid,
    input  lc3b_types_pkg::lc3b_opcode                id_ex_opcode,
    input  logic                                      id_ex_valid,
    input  lc3b_types_pkg::lc3b_word                  ex_mem_alu,
    input  lc3b_types_pkg::lc3b_word                  ex_mem_pcn,
    input  lc3b_types_pkg::lc3b_control_word          ex_mem_control,
    input  lc3b_types_pkg::lc3b_opcode                ex_mem_opcode,
    input  logic                                      ex_mem_valid,
    input  logic                                      mem_br_en,
    input  lc3b_types_pkg::lc3b_word                  mem_wb_mdr,
    input  lc3b_types_pkg::lc3b_control_word          mem_wb_control,
    input  lc3b_types_pkg::lc3b_opcode                mem_wb_opcode,
    input  logic                                      mem_wb_valid,
    output lc3b_types_pkg::lc3b_word                  pc_out,
    output lc3b_types_pkg::lc3b_word                  pc_plus2_out,
    output lc3b_types_pkg::lc3b_pipeline_control_word control_request,
    output logic                                      prediction_correct,
    output logic                                      prediction_incorrect
);

    import lc3b_types_pkg::*;

    lc3b_word       branch_offset;
    lc3b_word       branch_target;
    lc3b_pc_mux_sel pc_sel;
    logic           jump_if_id;
    logic           jump_id_ex;
    logic           jump_ex_mem;
    logic           trap_mem_wb;
    logic           suppress_branch;
    logic           if_branch;
    logic           ex_mem_branch;
    logic           mispredict;
    logic           pred_taken;
    logic           queue_load;
    lc3b_word       queue_address_in;
    lc3b_word       queue_mispredict_address;
    logic           queue_prediction;

    function automatic logic is_redirect(input lc3b_opcode op);
        return (op == op_jmp) || (op == op_jsr) || (op == op_trap);
    endfunction

    assign pc_plus2_out  = if_pc + 16'd2;
    assign branch_offset = {{6{if_ir.br.offset9[8]}}, if_ir.br.offset9, 1'b0};
    assign branch_target = pc_plus2_out + branch_offset;

    assign if_branch     = if_valid && (if_ir.gen.opcode == op_br);
    assign ex_mem_branch = ex_mem_valid && (ex_mem_opcode == op_br);
    assign mispredict    = ex_mem_branch && (queue_prediction != mem_br_en);

    assign jump_if_id  = if_id_valid && is_redirect(if_id_opcode);
    assign jump_id_ex  = id_ex_valid && is_redirect(id_ex_opcode);
    assign jump_ex_mem = ex_mem_valid && is_redirect(ex_mem_opcode);
    assign trap_mem_wb = mem_wb_valid && (mem_wb_opcode == op_trap);

    // fetch behind a jump or trap is dead, so no branch there is queued.
    assign suppress_branch = jump_if_id || jump_id_ex || jump_ex_mem || trap_mem_wb;

    assign prediction_correct   = ex_mem_branch && !mispredict;
    assign prediction_incorrect = mispredict;

    always_comb begin
        control_request  = '0; // stall fields stay zero.
        pc_sel           = pc_plus2;
        queue_load       = 1'b0;
        queue_address_in = branch_target;

        if (if_branch && !suppress_branch) begin
            queue_load = 1'b1;
            if (pred_taken) begin
                pc_sel           = branch_address;
                queue_address_in = pc_plus2_out;
            end
        end

        if (jump_if_id) begin
            control_request.active              = 1'b1;
            control_request.barrier_IF_ID_reset = 1'b1;
        end

        if (jump_id_ex) begin
            control_request.active              = 1'b1;
            control_request.barrier_IF_ID_reset = 1'b1;
            control_request.barrier_ID_EX_reset = 1'b1;
        end

        if (jump_ex_mem) begin
            control_request.active               = 1'b1;
            control_request.barrier_IF_ID_reset  = 1'b1;
            control_request.barrier_ID_EX_reset  = 1'b1;
            control_request.barrier_EX_MEM_reset = 1'b1;
            if (ex_mem_opcode != op_trap) begin
                pc_sel = ex_mem_control.pc_mux_sel; // alu or pcn.
            end
        end

        // trap vector comes back through the mdr.
        if (trap_mem_wb) begin
            control_request.active               = 1'b1;
            control_request.barrier_IF_ID_reset  = 1'b1;
            control_request.barrier_ID_EX_reset  = 1'b1;
            control_request.barrier_EX_MEM_reset = 1'b1;
            control_request.barrier_MEM_WB_reset = 1'b1;
            pc_sel = mem_wb_control.pc_mux_sel;
        end

        if (mispredict) begin
            control_request.active               = 1'b1;
            control_request.barrier_IF_ID_reset  = 1'b1;
            control_request.barrier_ID_EX_reset  = 1'b1;
            control_request.barrier_EX_MEM_reset = 1'b1;
            pc_sel     = mispredict_address;
            queue_load = 1'b0; // fetched branch is flushed too.
        end
    end

    always_comb begin
        case (pc_sel)
            alu:                pc_out = ex_mem_alu;
            pcn:                pc_out = ex_mem_pcn;
            mdr:                pc_out = mem_wb_mdr;
            branch_address:     pc_out = branch_target;
            mispredict_address: pc_out = queue_mispredict_address;
            default:            pc_out = pc_plus2_out;
        endcase
    end

    branch_predictor #(
        .PRED_INDEX_BITS(PRED_INDEX_BITS),
        .QUEUE_DEPTH    (QUEUE_DEPTH)
    ) u_predictor (
        .clk         (clk),
        .reset       (reset),
        .stall       (stall),
        .flush       (mispredict),
        .load        (queue_load),
        .pc          (if_pc),
        .update      (ex_mem_branch),
        .update_value(mem_br_en),
        .prediction  (pred_taken)
    );

    // younger entries die with a mispredict, so it empties the queue.
    branch_waterfall_queue #(
        .QUEUE_DEPTH(QUEUE_DEPTH)
    ) u_queue (
        .clk                  (clk),
        .reset                (reset),
        .stall                (stall),
        .flush                (mispredict),
        .load                 (queue_load),
        .mispredict_address_in(queue_address_in),
        .prediction_in        (pred_taken),
        .update               (ex_mem_branch),
        .correct              (prediction_correct),
        .mispredict_address   (queue_mispredict_address),
        .prediction           (queue_prediction)
    );

endmodule

// File: design/lc3b_branch_unit.sv
`timescale 1ns/100ps

module lc3b_branch_unit #(
    parameter int PRED_INDEX_BITS = lc3b_types_pkg::PRED_INDEX_BITS,
    parameter int QUEUE_DEPTH     = lc3b_types_pkg::QUEUE_DEPTH
) (
    input  logic                                      clk,
    input  logic                                      reset,
    input  logic                                      stall,
    input  lc3b_types_pkg::lc3b_instr                 if_ir,
    input  lc3b_types_pkg::lc3b_word                  if_pc,
    input  logic                                      if_valid,
    input  lc3b_types_pkg::lc3b_opcode                if_id_opcode,
    input  logic                                      if_id_valid,
    input  lc3b_types_pkg::lc3b_opcode                id_ex_opcode,
    input  logic                                      id_ex_valid,
    input  lc3b_types_pkg::lc3b_word                  ex_mem_alu,
    input  lc3b_types_pkg::lc3b_word                  ex_mem_pcn,
    input  lc3b_types_pkg::lc3b_control_word          ex_mem_control,
    input  lc3b_types_pkg::lc3b_opcode                ex_mem_opcode,
    input  logic                                      ex_mem_valid,
    input  logic                                      mem_br_en,
    input  lc3b_types_pkg::lc3b_word                  mem_wb_mdr,
    input  lc3b_types_pkg::lc3b_control_word          mem_wb_control,
    input  lc3b_types_pkg::lc3b_opcode                mem_wb_opcode,
    input  logic                                      mem_wb_valid,
    output lc3b_types_pkg::lc3b_word                  pc_out,
    output lc3b_types_pkg::lc3b_word                  pc_plus2_out,
    output lc3b_types_pkg::lc3b_pipeline_control_word control_request,
    output logic                                      prediction_correct,
    output logic                                      prediction_incorrect
);

    // barrier state in, next fetch pc and flush request out.
    branch_controller #(
        .PRED_INDEX_BITS(PRED_INDEX_BITS),
        .QUEUE_DEPTH    (QUEUE_DEPTH)
    ) u_controller (
        .clk                 (clk),
        .reset               (reset),
        .stall               (stall),
        .if_ir               (if_ir),
        .if_pc               (if_pc),
        .if_valid            (if_valid),
        .if_id_opcode        (if_id_opcode),
        .if_id_valid         (if_id_valid),
        .id_ex_opcode        (id_ex_opcode),
        .id_ex_valid         (id_ex_valid),
        .ex_mem_alu          (ex_mem_alu),
        .ex_mem_pcn          (ex_mem_pcn),
        .ex_mem_control      (ex_mem_control),
        .ex_mem_opcode       (ex_mem_opcode),
        .ex_mem_valid        (ex_mem_valid),
        .mem_br_en           (mem_br_en),
        .mem_wb_mdr          (mem_wb_mdr),
        .mem_wb_control      (mem_wb_control),
        .mem_wb_opcode       (mem_wb_opcode),
        .mem_wb_valid        (mem_wb_valid),
        .pc_out              (pc_out),
        .pc_plus2_out        (pc_plus2_out),
        .control_request     (control_request),
        .prediction_correct  (prediction_correct),
        .prediction_incorrect(prediction_incorrect)
    );

endmodule

// File: dv/branch_unit_chk.sv
`timescale 1ns/100ps

module branch_unit_chk #(
    parameter int QUEUE_DEPTH = lc3b_types_pkg::QUEUE_DEPTH
) (
    input logic                                      clk,
    input logic                                      reset,
    input logic                                      stall,
    input logic                                      prediction_correct,
    input logic                                      prediction_incorrect,
    input lc3b_types_pkg::lc3b_pipeline_control_word control_request,
    input logic                                      queue_pop,
    input logic [$clog2(QUEUE_DEPTH+1)-1:0]          queue_count,
    input logic                                      queue_prediction,
    input lc3b_types_pkg::lc3b_word                  queue_address,
    input logic [15:0]                               queue_hits
);

    a_one_pulse: assert property (@(posedge clk) disable iff (reset)
        !(prediction_correct && prediction_incorrect))
        else $error("correct and incorrect pulses high in the same cycle");

    a_active_resets_if_id: assert property (@(posedge clk) disable iff (reset)
        control_request.active |-> control_request.barrier_IF_ID_reset)
        else $error("active request without an IF/ID reset");

    a_pop_not_empty: assert property (@(posedge clk) disable iff (reset)
        (queue_pop && !stall) |-> (queue_count != '0))
        else $error("prediction queue popped while empty");

    // a stalled edge leaves the queue untouched.
    a_stall_freezes: assert property (@(posedge clk) disable iff (reset)
        stall |=> $stable(queue_count) && $stable(queue_prediction) &&
                  $stable(queue_address) && $stable(queue_hits))
        else $error("queue state changed under stall");

    // each correct resolution adds one hit.
    a_hit_counted: assert property (@(posedge clk) disable iff (reset)
        (prediction_correct && !stall) |=> queue_hits == $past(queue_hits) + 16'd1)
        else $error("hit counter missed a correct prediction");

endmodule

bind branch_controller branch_unit_chk #(
    .QUEUE_DEPTH(QUEUE_DEPTH)
) u_chk (
    .clk                 (clk),
    .reset               (reset),
    .stall               (stall),
    .prediction_correct  (prediction_correct),
    .prediction_incorrect(prediction_incorrect),
    .control_request     (control_request),
    .queue_pop           (ex_mem_branch),
    .queue_count         (u_queue.count),
    .queue_prediction    (queue_prediction),
    .queue_address       (queue_mispredict_address),
    .queue_hits          (u_queue.hit_count)
);

// File: dv/tb_lc3b_branch_unit.sv
`timescale 1ns/100ps

module tb_lc3b_branch_unit;

    import lc3b_types_pkg::*;

    localparam int INDEX_BITS   = 4;
    localparam int DEPTH        = 4;
    localparam int NUM_OPS      = 2000;
    localparam int RESET_CYCLES = 3;
    localparam int CYCLE_LIMIT  = NUM_OPS + RESET_CYCLES + 100;

    typedef struct packed {
        logic             valid;
        lc3b_opcode       opcode;
        lc3b_control_word control;
    } barrier_state;

    typedef struct packed {
        logic                  taken;
        lc3b_word              alternate; // path not predicted.
        logic [INDEX_BITS-1:0] index;
    } queued_branch;

    logic                      clk;
    logic                      reset;
    logic                      stall;
    lc3b_instr                 if_ir;
    lc3b_word                  if_pc;
    logic                      if_valid;
    lc3b_opcode                if_id_opcode;
    logic                      if_id_valid;
    lc3b_opcode                id_ex_opcode;
    logic                      id_ex_valid;
    lc3b_word                  ex_mem_alu;
    lc3b_word                  ex_mem_pcn;
    lc3b_control_word          ex_mem_control;
    lc3b_opcode                ex_mem_opcode;
    logic                      ex_mem_valid;
    logic                      mem_br_en;
    lc3b_word                  mem_wb_mdr;
    lc3b_control_word          mem_wb_control;
    lc3b_opcode                mem_wb_opcode;
    logic                      mem_wb_valid;
    lc3b_word                  pc_out;
    lc3b_word                  pc_plus2_out;
    lc3b_pipeline_control_word control_request;
    logic                      prediction_correct;
    logic                      prediction_incorrect;

    integer       seed;
    int           cycle_count;
    logic [1:0]   counter_model [2**INDEX_BITS];
    queued_branch pending [$];
    barrier_state if_id;
    barrier_state id_ex;
    barrier_state ex_mem;
    barrier_state mem_wb;
    lc3b_word     fetch_pc;
    logic [15:0]  fetch_word;
    logic         fetch_valid;
    lc3b_opcode   plain_ops [6] = '{op_add, op_and, op_ldr, op_str, op_lea, op_not};

    lc3b_branch_unit #(
        .PRED_INDEX_BITS(INDEX_BITS),
        .QUEUE_DEPTH    (DEPTH)
    ) DUT (.*);

    always #4 clk = ~clk;

    always @(posedge clk) begin
        cycle_count = cycle_count + 1;
        if (cycle_count >= CYCLE_LIMIT) begin
            abort_run("timeout: the run went past its cycle limit");
        end
    end

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("SIMULATION FAILED");
        $fatal(1, "run stopped at first error");
    endtask

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            abort_run($sformatf("CHECK FAILED: %s got 0x%h expected 0x%h", name, got, exp));
        end
    endtask

    function automatic logic changes_flow(input barrier_state b);
        return b.valid && (b.opcode == op_jmp || b.opcode == op_jsr || b.opcode == op_trap);
    endfunction

    function automatic lc3b_control_word decode_control(input lc3b_opcode op, input logic use_pcn);
        lc3b_control_word control;
        control = '0;
        if (op == op_jmp) control.pc_mux_sel = alu;
        else if (op == op_jsr) control.pc_mux_sel = use_pcn ? pcn : alu;
        else if (op == op_trap) control.pc_mux_sel = mdr; // trap vector read from memory.
        return control;
    endfunction

    // random instruction mix, about a third branches.
    task automatic fetch_next();
        int         pick;
        lc3b_opcode op;
        pick = int'($unsigned($random(seed)) % 100);
        if (pick < 30) op = op_br;
        else if (pick < 38) op = op_jmp;
        else if (pick < 46) op = op_jsr;
        else if (pick < 52) op = op_trap;
        else op = plain_ops[$unsigned($random(seed)) % 6];
        fetch_word  = {op, 12'($random(seed))};
        fetch_valid = ($unsigned($random(seed)) % 10) != 0;
    endtask

    task automatic drive_inputs();
        stall          = ($unsigned($random(seed)) % 10) == 0;
        if_pc          = fetch_pc;
        if_ir          = fetch_word;
        if_valid       = fetch_valid;
        if_id_opcode   = if_id.opcode;
        if_id_valid    = if_id.valid;
        id_ex_opcode   = id_ex.opcode;
        id_ex_valid    = id_ex.valid;
        ex_mem_opcode  = ex_mem.opcode;
        ex_mem_valid   = ex_mem.valid;
        ex_mem_control = ex_mem.control;
        mem_wb_opcode  = mem_wb.opcode;
        mem_wb_valid   = mem_wb.valid;
        mem_wb_control = mem_wb.control;
        ex_mem_alu     = 16'($random(seed));
        ex_mem_pcn     = 16'($random(seed));
        mem_wb_mdr     = 16'($random(seed));
        mem_br_en      = ($unsigned($random(seed)) % 8) < 5;
    endtask

    task automatic step_model();
        logic                      resolving;
        logic                      wrong;
        logic                      load;
        logic                      taken;
        logic [INDEX_BITS-1:0]     index;
        lc3b_word                  next_seq;
        lc3b_word                  target;
        lc3b_word                  alternate;
        lc3b_word                  exp_pc;
        lc3b_pipeline_control_word exp_request;
        lc3b_opcode                fetched_op;
        int                        depth;
        int                        slot;

        next_seq  = fetch_pc + 16'd2;
        target    = next_seq + (lc3b_word'($signed(fetch_word[8:0])) << 1);
        index     = fetch_pc[INDEX_BITS:1];
        taken     = counter_model[index][1];
        resolving = ex_mem.valid && ex_mem.opcode == op_br;
        wrong     = 1'b0;
        if (resolving && pending.size() == 0) begin
            abort_run("a branch reached EX/MEM with no prediction queued");
        end else if (resolving) begin
            wrong = pending[0].taken != mem_br_en;
        end

        // number of barriers reset, deepest request wins.
        depth = 0;
        if (changes_flow(if_id)) depth = 1;
        if (changes_flow(id_ex)) depth = 2;
        if (changes_flow(ex_mem)) depth = 3;
        if (mem_wb.valid && mem_wb.opcode == op_trap) depth = 4;
        if (wrong && depth < 3) depth = 3;

        load      = fetch_valid && fetch_word[15:12] == op_br && depth == 0;
        exp_pc    = (load && taken) ? target : next_seq;
        alternate = (load && taken) ? next_seq : target;
        if (changes_flow(ex_mem) && ex_mem.opcode != op_trap) begin
            exp_pc = (ex_mem.control.pc_mux_sel == pcn) ? ex_mem_pcn : ex_mem_alu;
        end
        if (depth == 4) exp_pc = mem_wb_mdr;
        if (wrong) exp_pc = pending[0].alternate;

        exp_request                      = '0;
        exp_request.active               = depth > 0;
        exp_request.barrier_IF_ID_reset  = depth >= 1;
        exp_request.barrier_ID_EX_reset  = depth >= 2;
        exp_request.barrier_EX_MEM_reset = depth >= 3;
        exp_request.barrier_MEM_WB_reset = depth >= 4;

        check("pc_out", {16'd0, pc_out}, {16'd0, exp_pc});
        check("pc_plus2_out", {16'd0, pc_plus2_out}, {16'd0, next_seq});
        check("control_request", {15'd0, control_request}, {15'd0, exp_request});
        check("prediction_correct", {31'd0, prediction_correct}, {31'd0, resolving && !wrong});
        check("prediction_incorrect", {31'd0, prediction_incorrect}, {31'd0, wrong});

        if (!stall) begin
            if (resolving) begin
                slot = int'(pending[0].index);
                if (mem_br_en && counter_model[slot] != 2'd3) counter_model[slot] += 2'd1;
                if (!mem_br_en && counter_model[slot] != 2'd0) counter_model[slot] -= 2'd1;
                void'(pending.pop_front());
            end
            if (wrong) pending.delete(); // younger predictions die with the flush.
            else if (load) pending.push_back('{taken, alternate, index});

            fetched_op = lc3b_opcode'(fetch_word[15:12]);
            mem_wb     = (depth >= 4) ? barrier_state'('0) : ex_mem;
            ex_mem     = (depth >= 3) ? barrier_state'('0) : id_ex;
            id_ex      = (depth >= 2) ? barrier_state'('0) : if_id;
            if (depth >= 1) begin
                if_id = '0;
            end else begin
                if_id = '{fetch_valid, fetched_op,
                          decode_control(fetched_op, ($random(seed) & 1) != 0)};
            end
            fetch_pc = exp_pc;
            fetch_next();
        end
    endtask

    initial begin
        seed        = 32'hd31e;
        cycle_count = 0;
        clk         = 1'b0;
        reset       = 1'b1;
        foreach (counter_model[i]) counter_model[i] = 2'b01; // weakly not-taken.
        if_id    = '0;
        id_ex    = '0;
        ex_mem   = '0;
        mem_wb   = '0;
        fetch_pc = 16'h3000;
        fetch_next();
        drive_inputs();
        stall = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);

        for (int n = 0; n < NUM_OPS; n++) begin
            @(negedge clk);
            reset = 1'b0;
            drive_inputs();
            #2;
            step_model();
        end
        $display("SIMULATION PASSED");
        $finish;
    end

endmodule

// File: lc3b_branch_unit.f
design/lc3b_types_pkg.sv
design/branch_predictor.sv
design/branch_waterfall_queue.sv
design/branch_controller.sv
design/lc3b_branch_unit.sv
dv/branch_unit_chk.sv
dv/tb_lc3b_branch_unit.sv

// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert --timescale 1ns/100ps -j 0
TOP       = tb_lc3b_branch_unit
FILELIST  = lc3b_branch_unit.f

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	@out="$$(./obj_dir/V$(TOP) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "SIMULATION PASSED"

clean:
	rm -rf obj_dir
